//--- Makefile
VERILATOR ?= verilator
TOP       ?= balance_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	  echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- src/balance_ctrl.sv
// sums the pid terms, mixes in steering, gates the wheel speeds by power and flags over-speed
`timescale 1ns/1ps
`include "balance_macros.svh"

module balance_ctrl (
  input  logic                   vld,          // new inertial reading
  input  logic                   rider_off,    // load cells see no rider
  input  logic                   pwr_up,       // platform authorized to move
  input  logic                   en_steer,     // rider is leaning to steer
  input  logic signed [11:0]     ld_cell_diff, // left minus right load
  pid_if.ctrl                    pid,
  output balance_pkg::torque_t   lft_torque,   // to shaper_lft
  output balance_pkg::torque_t   rght_torque,  // to shaper_rght
  input  logic [`BAL_SPD_W-1:0]  lft_spd_raw,  // back from the shapers
  input  logic [`BAL_SPD_W-1:0]  rght_spd_raw,
  output logic [`BAL_SPD_W-1:0]  lft_spd,
  output logic [`BAL_SPD_W-1:0]  rght_spd,
  output logic                   ovr_spd       // warns the rider through the piezo
);

  localparam logic [`BAL_SPD_W-1:0] OVR_LIMIT = `BAL_OVR_SPD;

  balance_pkg::torque_t i_gated;    // i term, dropped while not powered
  balance_pkg::torque_t pid_sum;
  balance_pkg::torque_t steer_ofs;  // ld_cell_diff / 8, sign extended

  ////////////////////
  // strobes to the datapath
  ////////////////////
  assign pid.smp       = vld;
  assign pid.integ_clr = rider_off;

  ////////////////////
  // pid sum
  ////////////////////

  // keeps the integral from pushing the wheels before power up
  assign i_gated = pwr_up ? pid.i_term : balance_pkg::torque_t'(0);
  assign pid_sum = pid.p_term + pid.d_term + i_gated;

  ////////////////////
  // steering mix
  ////////////////////
  assign steer_ofs = balance_pkg::torque_t'(ld_cell_diff >>> `BAL_STEER_SHIFT);

  always_comb begin
    if (en_steer) begin
      lft_torque  = pid_sum - steer_ofs;  // heavier left slows the left wheel
      rght_torque = pid_sum + steer_ofs;
    end else begin
      lft_torque  = pid_sum;              // straight line, both wheels alike
      rght_torque = pid_sum;
    end
  end

  ////////////////////
  // speed gating
  ////////////////////
  assign lft_spd  = pwr_up ? lft_spd_raw  : '0;
  assign rght_spd = pwr_up ? rght_spd_raw : '0;

  // a saturated 2047 trips this too
  assign ovr_spd = (lft_spd > OVR_LIMIT) || (rght_spd > OVR_LIMIT);

  // unpowered platform never drives a wheel or sounds the warning
  a_pwr_gate : assert property (
    @(posedge pid.clk)
    !pwr_up |-> ((lft_spd == '0) && (rght_spd == '0) && !ovr_spd)
  ) else $error("wheel speed nonzero while pwr_up is low");

endmodule

//--- src/balance_macros.svh
// gains, thresholds and word widths for the balance controller, included by the RTL that needs them
`ifndef BALANCE_MACROS_SVH
`define BALANCE_MACROS_SVH

////////////////////
// pid gains
////////////////////
`define BAL_P_COEFF 14         // proportional gain
`define BAL_D_COEFF 20         // derivative gain

////////////////////
// torque shaping
////////////////////
`define BAL_LOW_TORQUE_BAND 70 // at or above this magnitude the min duty offset applies
`define BAL_GAIN_MULT 15       // small torque multiplier, about 1 + min_duty/band
`define BAL_MIN_DUTY 980       // offset that stiffens the motor out of its dead band
`define BAL_OVR_SPD 1536       // speed above this raises ovr_spd

////////////////////
// word widths
////////////////////
`define BAL_ERR_W 10           // saturated pitch error
`define BAL_DDIFF_W 7          // saturated derivative difference
`define BAL_INTEG_W 18         // integrator accumulator
`define BAL_ITERM_W 12         // upper accumulator slice used as the i term
`define BAL_TORQ_W 16          // torque and pid term words
`define BAL_SPD_W 11           // unsigned motor speed

// steering offset is ld_cell_diff / 8
`define BAL_STEER_SHIFT 3

`endif

//--- src/balance_pkg.sv
// shared types of the balance controller datapath, referenced by scoped name from the RTL
`include "balance_macros.svh"

package balance_pkg;

  // saturated pitch error, -512..511
  typedef logic signed [`BAL_ERR_W-1:0] ptch_err_t;

  // torque and term word, shared by p, i, d and the wheel torques
  typedef logic signed [`BAL_TORQ_W-1:0] torque_t;

  ////////////////////
  // integrator word
  ////////////////////

  // accumulator split into its integer i term and the fraction below it
  typedef struct packed {
    logic signed [`BAL_ITERM_W-1:0]             i_term; // acc >>> 6
    logic [`BAL_INTEG_W-`BAL_ITERM_W-1:0]       frac;   // dropped from the pid sum
  } integ_split_t;

  // stored as acc, read back through split
  typedef union packed {
    logic signed [`BAL_INTEG_W-1:0] acc;
    integ_split_t                   split;
  } integ_word_u;

endpackage

//--- src/balance_top.sv
// balance controller top level with plain ports, wiring the pid blocks, control and both wheel shapers
`timescale 1ns/1ps
`include "balance_macros.svh"

module balance_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  vld,           // new inertial reading
  input  logic signed [15:0]    ptch,          // measured pitch
  input  logic signed [11:0]    ld_cell_diff,  // left minus right load
  input  logic                  rider_off,
  input  logic                  en_steer,
  input  logic                  pwr_up,
  output logic [`BAL_SPD_W-1:0] lft_spd,
  output logic                  lft_rev,
  output logic [`BAL_SPD_W-1:0] rght_spd,
  output logic                  rght_rev,
  output logic                  ovr_spd
);

  balance_pkg::torque_t  lft_torque;    // control to shapers
  balance_pkg::torque_t  rght_torque;
  logic [`BAL_SPD_W-1:0] lft_spd_raw;   // shapers back to control for gating
  logic [`BAL_SPD_W-1:0] rght_spd_raw;

  pid_if pid0 (.clk(clk));

  ////////////////////
  // pid terms
  ////////////////////
  pitch_err_stage err0 (
    .pid  (pid0.err_src),
    .ptch (ptch)
  );

  integ_term integ0 (.clk(clk), .rst_n(rst_n), .pid(pid0.integ));

  deriv_term deriv0 (.clk(clk), .rst_n(rst_n), .pid(pid0.deriv));

  ////////////////////
  // control and shaping
  ////////////////////
  balance_ctrl ctrl0 (
    .vld          (vld),
    .rider_off    (rider_off),
    .pwr_up       (pwr_up),
    .en_steer     (en_steer),
    .ld_cell_diff (ld_cell_diff),
    .pid          (pid0.ctrl),
    .lft_torque   (lft_torque),
    .rght_torque  (rght_torque),
    .lft_spd_raw  (lft_spd_raw),
    .rght_spd_raw (rght_spd_raw),
    .lft_spd      (lft_spd),
    .rght_spd     (rght_spd),
    .ovr_spd      (ovr_spd)
  );

  torque_shaper shaper_lft  (.torque(lft_torque),  .spd_raw(lft_spd_raw),  .rev(lft_rev));
  torque_shaper shaper_rght (.torque(rght_torque), .spd_raw(rght_spd_raw), .rev(rght_rev));

endmodule

//--- src/deriv_term.sv
// keeps a two sample error history and forms the saturated derivative term from it
`timescale 1ns/1ps
`include "balance_macros.svh"

module deriv_term (
  input logic clk,
  input logic rst_n,
  pid_if.deriv pid
);

  // clamp range of the difference, -64..63
  localparam int DIFF_MAX = (1 << (`BAL_DDIFF_W - 1)) - 1;
  localparam int DIFF_MIN = -(1 << (`BAL_DDIFF_W - 1));

  localparam balance_pkg::torque_t D_GAIN = balance_pkg::torque_t'(`BAL_D_COEFF);

  balance_pkg::ptch_err_t     hist1;     // error at the last sample
  balance_pkg::ptch_err_t     hist2;     // error two samples back
  logic signed [`BAL_ERR_W:0] diff;      // one bit wider than the error, no wrap
  logic signed [`BAL_ERR_W:0] diff_sat;

  ////////////////////
  // history
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      hist1 <= '0;
      hist2 <= '0;
    end else if (pid.smp) begin
      hist1 <= pid.ptch_err;
      hist2 <= hist1;                    // shift down one
    end
  end

  // current error against the one two samples old
  assign diff = pid.ptch_err - hist2;

  always_comb begin
    if (diff > DIFF_MAX) begin
      diff_sat = DIFF_MAX[`BAL_ERR_W:0];
    end else if (diff < DIFF_MIN) begin
      diff_sat = DIFF_MIN[`BAL_ERR_W:0];
    end else begin
      diff_sat = diff;
    end
  end

  assign pid.d_term = balance_pkg::torque_t'(diff_sat) * D_GAIN; // |d| <= 1280

  a_diff_range : assert property (
    @(posedge clk) disable iff (!rst_n)
    (diff_sat >= DIFF_MIN) && (diff_sat <= DIFF_MAX)
  ) else $error("derivative difference left the 7 bit range");

endmodule

//--- src/integ_term.sv
// accumulates the pitch error on each sample and hands the upper slice to the pid sum as the i term
`timescale 1ns/1ps
`include "balance_macros.svh"

module integ_term (
  input logic clk,
  input logic rst_n,
  pid_if.integ pid
);

  localparam int MSB = `BAL_INTEG_W - 1;

  balance_pkg::integ_word_u integ_q;     // accumulator register
  logic signed [MSB:0]      integ_nxt;   // accumulator plus current error
  logic signed [MSB:0]      err_ext;     // error widened to the accumulator
  logic                     ovfl;        // sum flipped sign against both operands

  assign err_ext = pid.ptch_err;         // signed to signed, sign extends

  ////////////////////
  // next value
  ////////////////////
  assign integ_nxt = integ_q.acc + err_ext;

  // overflow only when both operands agree in sign and the sum does not
  assign ovfl = (integ_q.acc[MSB] == err_ext[MSB]) &&
                (integ_nxt[MSB] != integ_q.acc[MSB]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      integ_q.acc <= '0;
    end else if (pid.integ_clr) begin
      integ_q.acc <= '0;                 // no rider, no windup, wins over smp
    end else if (pid.smp && !ovfl) begin
      integ_q.acc <= integ_nxt;          // freeze on overflow
    end
  end

  ////////////////////
  // i term
  ////////////////////

  // upper 12 bits of the accumulator, same as acc >>> 6
  assign pid.i_term = balance_pkg::torque_t'(integ_q.split.i_term);

  // between samples and clears the accumulator must hold still
  a_integ_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    (!pid.smp && !pid.integ_clr) |=> $stable(integ_q.acc)
  ) else $error("integrator moved without smp or integ_clr");

endmodule

//--- src/pid_if.sv
// bundle between the control module and the three pid term blocks, one instance inside the top
`timescale 1ns/1ps

interface pid_if (
  input logic clk                  // only the control side samples it, for its checks
);

  logic                  smp;      // new inertial sample, one cycle strobe
  logic                  integ_clr; // rider has stepped off, dump the integrator

  balance_pkg::ptch_err_t ptch_err; // clamped pitch
  balance_pkg::torque_t   p_term;
  balance_pkg::torque_t   i_term;
  balance_pkg::torque_t   d_term;

  ////////////////////
  // modports
  ////////////////////

  // control drives the strobes and collects the terms
  modport ctrl (
    input  clk,
    output smp, integ_clr,
    input  p_term, i_term, d_term
  );

  modport err_src (output ptch_err, p_term);

  modport integ (
    input  smp, integ_clr, ptch_err,
    output i_term
  );

  modport deriv (
    input  smp, ptch_err,
    output d_term
  );

endinterface

//--- src/pitch_err_stage.sv
// clamps the measured pitch into the error width and forms the proportional term from it
`timescale 1ns/1ps
`include "balance_macros.svh"

module pitch_err_stage (
  pid_if.err_src      pid,
  input logic signed [15:0] ptch    // raw pitch from the inertial block
);

  // saturation limits of the error word
  localparam logic signed [15:0] ERR_MAX = 16'sd511;
  localparam logic signed [15:0] ERR_MIN = -16'sd512;

  localparam balance_pkg::torque_t P_GAIN = balance_pkg::torque_t'(`BAL_P_COEFF);

  balance_pkg::ptch_err_t err_sat;

  ////////////////////
  // saturation
  ////////////////////
  always_comb begin
    if (ptch > ERR_MAX) begin
      err_sat = balance_pkg::ptch_err_t'(ERR_MAX);     // pinned at +511
    end else if (ptch < ERR_MIN) begin
      err_sat = balance_pkg::ptch_err_t'(ERR_MIN);     // pinned at -512
    end else begin
      err_sat = ptch[`BAL_ERR_W-1:0];                   // already in range
    end
  end

  assign pid.ptch_err = err_sat;

  // 14 * 511 fits easily in 16 bits, so no saturation on the product
  assign pid.p_term = balance_pkg::torque_t'(err_sat) * P_GAIN;

endmodule

//--- src/torque_shaper.sv
// shapes one wheel's signed torque into a saturated motor speed and a reverse bit, one per wheel
`timescale 1ns/1ps
`include "balance_macros.svh"

module torque_shaper (
  input  balance_pkg::torque_t   torque,  // steered pid command for this wheel
  output logic [`BAL_SPD_W-1:0]  spd_raw, // ungated speed magnitude
  output logic                   rev      // 1 runs the wheel backwards
);

  localparam int MSB = `BAL_TORQ_W - 1;

  localparam logic [MSB:0]         BAND     = `BAL_LOW_TORQUE_BAND;
  localparam balance_pkg::torque_t MIN_DUTY = balance_pkg::torque_t'(`BAL_MIN_DUTY);
  localparam balance_pkg::torque_t GAIN     = balance_pkg::torque_t'(`BAL_GAIN_MULT);

  logic [MSB:0]         torq_mag;   // unsigned, so -32768 still compares right
  balance_pkg::torque_t duty_ofs;   // torque pushed away from zero
  balance_pkg::torque_t gain_torq;  // torque scaled up inside the band
  balance_pkg::torque_t shaped;
  logic [MSB:0]         shaped_mag;

  assign torq_mag = torque[MSB] ? -torque : torque;

  ////////////////////
  // shaping
  ////////////////////
  assign duty_ofs  = torque[MSB] ? (torque - MIN_DUTY) : (torque + MIN_DUTY);
  assign gain_torq = torque * GAIN;  // |torque| < 70 here, no overflow

  // large torque gets the min duty step, small torque the steeper gain
  assign shaped = (torq_mag >= BAND) ? duty_ofs : gain_torq;

  assign rev = shaped[MSB];          // sign of the shaped value

  ////////////////////
  // speed
  ////////////////////
  assign shaped_mag = shaped[MSB] ? -shaped : shaped;

  // anything past 11 bits pins at 2047
  assign spd_raw = (|shaped_mag[MSB:`BAL_SPD_W]) ? '1 : shaped_mag[`BAL_SPD_W-1:0];

endmodule

//--- tb.f
+incdir+src
src/balance_pkg.sv
src/pid_if.sv
src/pitch_err_stage.sv
src/integ_term.sv
src/deriv_term.sv
src/torque_shaper.sv
src/balance_ctrl.sv
src/balance_top.sv
tests/balance_checker.sv
tests/balance_tb.sv

//--- tests/balance_checker.sv
// watches the balance controller outputs and compares them with the expected row values on each strobe
`timescale 1ns/1ps
`include "balance_macros.svh"

module balance_checker (
  input  logic                  clk,
  input  logic                  chk,            // one row ready to compare
  input  int                    row,            // row index, only for the error lines
  input  logic [`BAL_SPD_W-1:0] want_lft_spd,
  input  logic [`BAL_SPD_W-1:0] want_rght_spd,
  input  logic                  want_lft_rev,
  input  logic                  want_rght_rev,
  input  logic                  want_ovr,
  input  logic [`BAL_SPD_W-1:0] lft_spd,        // dut outputs
  input  logic [`BAL_SPD_W-1:0] rght_spd,
  input  logic                  lft_rev,
  input  logic                  rght_rev,
  input  logic                  ovr_spd,
  output int                    err_cnt,
  output int                    chk_cnt
);

  int errs   = 0;   // mismatching fields over the run
  int checks = 0;   // rows compared

  assign err_cnt = errs;
  assign chk_cnt = checks;

  ////////////////////
  // compare
  ////////////////////

  // !== so an x on an output counts as a mismatch
  task automatic compare_val(input string name, input logic [15:0] got,
                             input logic [15:0] expd);
    if (got !== expd) begin
      $display("Fail %s row %0d: got 0x%h, expected 0x%h", name, row, got, expd);
      errs++;
    end
  endtask

  // inputs move on the rising edge, so the falling edge sees settled outputs
  always @(negedge clk) begin
    if (chk) begin
      checks++;
      compare_val("lft_spd", 16'(lft_spd), 16'(want_lft_spd));
      compare_val("rght_spd", 16'(rght_spd), 16'(want_rght_spd));
      compare_val("lft_rev", 16'(lft_rev), 16'(want_lft_rev));
      compare_val("rght_rev", 16'(rght_rev), 16'(want_rght_rev));
      compare_val("ovr_spd", 16'(ovr_spd), 16'(want_ovr));   // trips above 1536
    end
  end

endmodule

//--- tests/balance_tb.sv
// testbench for the balance controller, runs the stimulus table row by row and prints the result
`timescale 1ns/1ps
`include "balance_macros.svh"

module balance_tb;

  localparam int NUM_ROWS  = 16;
  localparam int RST_CYC   = 5;
  localparam int ROW_CYC   = 5;   // rider clear, two samples, idle, check
  localparam int CYC_LIMIT = NUM_ROWS * ROW_CYC + RST_CYC + 50;

  typedef struct packed {
    logic signed [15:0]    ptch_a;    // first sample
    logic signed [15:0]    ptch_b;    // second sample, held through the check
    logic signed [11:0]    ld;
    logic                  steer;
    logic                  pwr;
    logic [`BAL_SPD_W-1:0] lft_spd;   // expected values from here on
    logic [`BAL_SPD_W-1:0] rght_spd;
    logic                  lft_rev;
    logic                  rght_rev;
    logic                  ovr;
  } row_t;

  row_t tbl [NUM_ROWS];

  logic                  clk;
  logic                  rst_n;
  logic                  vld;
  logic signed [15:0]    ptch;
  logic signed [11:0]    ld_cell_diff;
  logic                  rider_off;
  logic                  en_steer;
  logic                  pwr_up;
  logic [`BAL_SPD_W-1:0] lft_spd;
  logic [`BAL_SPD_W-1:0] rght_spd;
  logic                  lft_rev;
  logic                  rght_rev;
  logic                  ovr_spd;

  logic                  chk;       // check strobe to chk0
  int                    chk_row;
  row_t                  want;      // expected fields of the row under check
  int                    err_cnt;
  int                    chk_cnt;
  int                    cyc_cnt;

  balance_top dut0 (
    .clk(clk), .rst_n(rst_n), .vld(vld), .ptch(ptch), .ld_cell_diff(ld_cell_diff),
    .rider_off(rider_off), .en_steer(en_steer), .pwr_up(pwr_up),
    .lft_spd(lft_spd), .lft_rev(lft_rev), .rght_spd(rght_spd), .rght_rev(rght_rev),
    .ovr_spd(ovr_spd)
  );

  balance_checker chk0 (
    .clk(clk), .chk(chk), .row(chk_row),
    .want_lft_spd(want.lft_spd), .want_rght_spd(want.rght_spd),
    .want_lft_rev(want.lft_rev), .want_rght_rev(want.rght_rev), .want_ovr(want.ovr),
    .lft_spd(lft_spd), .rght_spd(rght_spd), .lft_rev(lft_rev), .rght_rev(rght_rev),
    .ovr_spd(ovr_spd), .err_cnt(err_cnt), .chk_cnt(chk_cnt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;   // 100 ns period
  end

  ////////////////////
  // stimulus table
  ////////////////////

  // pid = 14*b + 20*clamp7(b-a) + ((a+b) >>> 6), then steer, shape, gate
  task automatic load_table();
    tbl[0]  = '{16'sd0, 16'sd0, 12'sd0, 1'b0, 1'b1, 11'd0, 11'd0, 1'b0, 1'b0, 1'b0};
    tbl[1]  = '{16'sd3, 16'sd3, 12'sd0, 1'b0, 1'b1, 11'd630, 11'd630, 1'b0, 1'b0, 1'b0};
    tbl[2]  = '{-16'sd2, -16'sd2, 12'sd0, 1'b0, 1'b1, 11'd435, 11'd435, 1'b1, 1'b1, 1'b0};
    tbl[3]  = '{16'sd5, 16'sd5, 12'sd0, 1'b0, 1'b1, 11'd1050, 11'd1050, 1'b0, 1'b0, 1'b0};
    // clamp to 511 and -512, far past the speed limit
    tbl[4]  = '{16'sd3000, 16'sd3000, 12'sd0, 1'b0, 1'b1, 11'd2047, 11'd2047, 1'b0, 1'b0, 1'b1};
    tbl[5]  = '{-16'sd3000, -16'sd3000, 12'sd0, 1'b0, 1'b1, 11'd2047, 11'd2047, 1'b1, 1'b1, 1'b1};
    tbl[6]  = '{16'sd10, 16'sd10, 12'sd0, 1'b0, 1'b1, 11'd1120, 11'd1120, 1'b0, 1'b0, 1'b0};
    tbl[7]  = '{-16'sd90, -16'sd20, 12'sd0, 1'b0, 1'b1, 11'd1958, 11'd1958, 1'b0, 1'b0, 1'b1};
    tbl[8]  = '{16'sd100, 16'sd30, 12'sd0, 1'b0, 1'b1, 11'd1838, 11'd1838, 1'b1, 1'b1, 1'b1};
    tbl[9]  = '{16'sd123, 16'sd60, 12'sd0, 1'b0, 1'b1, 11'd1398, 11'd1398, 1'b1, 1'b1, 1'b0};
    tbl[10] = '{16'sd123, 16'sd60, 12'sd0, 1'b0, 1'b0, 11'd0, 11'd0, 1'b1, 1'b1, 1'b0};
    tbl[11] = '{16'sd3000, 16'sd3000, 12'sd0, 1'b0, 1'b0, 11'd0, 11'd0, 1'b0, 1'b0, 1'b0};
    // steering, left wheel drops into reverse
    tbl[12] = '{16'sd3, 16'sd3, 12'sd400, 1'b1, 1'b1, 11'd120, 11'd1072, 1'b1, 1'b0, 1'b0};
    tbl[13] = '{16'sd10, 16'sd10, -12'sd300, 1'b1, 1'b1, 11'd1158, 11'd1082, 1'b0, 1'b0, 1'b0};
    tbl[14] = '{16'sd3, 16'sd3, 12'sd400, 1'b0, 1'b1, 11'd630, 11'd630, 1'b0, 1'b0, 1'b0};
    tbl[15] = '{-16'sd10, -16'sd10, 12'sd0, 1'b0, 1'b1, 11'd1121, 11'd1121, 1'b1, 1'b1, 1'b0};
  endtask

  // one row is five edges, the check strobe stays up until the next row starts
  task automatic apply_row(input int idx);
    @(posedge clk);
    chk          <= 1'b0;
    rider_off    <= 1'b1;              // dump the integrator
    ld_cell_diff <= tbl[idx].ld;
    en_steer     <= tbl[idx].steer;
    pwr_up       <= tbl[idx].pwr;
    @(posedge clk);
    rider_off <= 1'b0;
    vld       <= 1'b1;
    ptch      <= tbl[idx].ptch_a;
    @(posedge clk);
    ptch <= tbl[idx].ptch_b;
    @(posedge clk);
    vld <= 1'b0;                       // idle, pitch stays at b
    @(posedge clk);
    chk     <= 1'b1;
    chk_row <= idx;
    want    <= tbl[idx];
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    load_table();
    rst_n        = 1'b0;
    vld          = 1'b0;
    ptch         = '0;
    ld_cell_diff = '0;
    rider_off    = 1'b0;
    en_steer     = 1'b0;
    pwr_up       = 1'b0;
    chk          = 1'b0;
    chk_row      = 0;
    want         = '0;
    repeat (RST_CYC) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_ROWS; i++) begin
      apply_row(i);
    end
    @(posedge clk);
    chk <= 1'b0;
    @(posedge clk);
    $display("%0d of %0d rows checked, %0d errors", chk_cnt, NUM_ROWS, err_cnt);
    if (err_cnt == 0 && chk_cnt == NUM_ROWS) begin
      $display("TESTS PASSED");
    end else begin
      if (chk_cnt != NUM_ROWS) begin
        $display("the checker did not see every row");
      end
      $display("TESTS FAILED");
    end
    $finish;
  end

  // watchdog, ends the run if the sequence stalls
  initial begin
    cyc_cnt = 0;
    while (cyc_cnt < CYC_LIMIT) begin
      @(posedge clk);
      cyc_cnt++;
    end
    $display("run did not finish within %0d cycles", CYC_LIMIT);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
